// File: rv64_core.f
+incdir+hw
hw/rv64_isa_pkg.sv
hw/rv64_core_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/exe_stage.sv
hw/regfile.sv
hw/csr_file.sv
hw/rv64_core.sv
tests/rv64_core_tb.sv

// File: Makefile
# Verilator build and run for the rv64 core testbench

VERILATOR ?= verilator
TOP       ?= rv64_core_tb
FILELIST  ?= rv64_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/rv64_core_tb.sv
// rv64 core random testbench
`timescale 1ns/10ps
`include "rv64_params.svh"

module rv64_core_tb;
  import rv64_isa_pkg::*;
  import rv64_core_pkg::*;

  localparam int num_inst    = 2000;
  localparam int drain_limit = 8;

  logic     clk;
  logic     rst;
  xlen_t    inst_addr;
  inst_t    inst;
  logic     dmem_ren;
  logic     dmem_wen;
  xlen_t    dmem_addr;
  xlen_t    dmem_wdata;
  xlen_t    dmem_rdata;
  logic     commit_valid;
  xlen_t    commit_pc;
  inst_t    commit_inst;
  logic     commit_wen;
  reg_idx_t commit_rd;
  xlen_t    commit_wdata;
  logic     commit_skip;

  // architectural state of the reference model
  xlen_t       ref_regs [32];
  xlen_t       ref_mem [256];
  xlen_t       ref_pc;
  xlen_t       ref_mscratch;
  xlen_t       ref_mtvec;
  logic [31:0] lcg_state;

  // expected retire of the instruction now on inst
  xlen_t    exp_pc;
  inst_t    exp_inst;
  logic     exp_wen;
  reg_idx_t exp_rd;
  xlen_t    exp_wdata;
  logic     exp_skip;
  logic     exp_dren;
  logic     exp_dwen;
  xlen_t    exp_daddr;
  xlen_t    exp_dwdata;
  xlen_t    exp_load;
  int       n_checked = 0;

  rv64_core i_rv64_core (
    .clk          (clk),
    .rst          (rst),
    .inst_addr    (inst_addr),
    .inst         (inst),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_wdata (commit_wdata),
    .commit_skip  (commit_skip)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("Error at %t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("Error at %t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      $display("Error at %t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // memory contents before any store and on the device page
  function automatic xlen_t fill_word(input xlen_t addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'h5a17_c0de_3c96_e1f0;
  endfunction

  function automatic logic is_device(input xlen_t addr);
    return (addr & ~64'hFFF) == `DEVICE_PAGE;
  endfunction

  function automatic inst_t enc_r(input funct7_t f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input funct3_t f3, input reg_idx_t rd, input opcode_t op);
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input funct3_t f3, input reg_idx_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input funct3_t f3, input opcode_t op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op, 2'b11};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPCODE_BRANCH, 2'b11};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input opcode_t op);
    return {imm, rd, op, 2'b11};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPCODE_JAL, 2'b11};
  endfunction

  function automatic inst_t rand_inst();
    logic [31:0] r1;
    logic [31:0] r2;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic [11:0] imm;
    logic [11:0] csr;
    inst_t       res;
    r1  = lcg_next();
    r2  = lcg_next();
    rd  = r1[31:27];
    rs1 = r1[26:22];
    rs2 = r1[21:17];
    // one of the six supported alu codes
    case (r1[16:14])
      3'd0, 3'd6: f3 = `FUNCT3_ADD;
      3'd1:       f3 = `FUNCT3_SLL;
      3'd2, 3'd7: f3 = `FUNCT3_XOR;
      3'd3:       f3 = `FUNCT3_SRL;
      3'd4:       f3 = `FUNCT3_OR;
      default:    f3 = `FUNCT3_AND;
    endcase
    imm = r2[19:8];
    case (r2[31:28])
      4'd0: res = enc_u(r2[27:8], rd, `OPCODE_LUI);
      4'd1: res = enc_u(r2[27:8], rd, `OPCODE_AUIPC);
      4'd2: res = enc_j({{11{r2[7]}}, r2[7:0], 2'b00}, rd);
      4'd3: res = enc_i({r2[11:2], 2'b00}, 5'd0, 3'b000, rd, `OPCODE_JALR);
      4'd4, 4'd5: res = enc_b({{3{r2[7]}}, r2[7:0], 2'b00}, rs2, rs1, {r2[9], 1'b0, r2[8]});
      4'd6, 4'd7, 4'd8: begin
        if (f3 == `FUNCT3_SLL || f3 == `FUNCT3_SRL) begin
          imm = {6'd0, r2[13:8]};
        end
        res = enc_i(imm, rs1, f3, rd, `OPCODE_OPIMM);
      end
      4'd9, 4'd10: begin
        res = enc_r((f3 == `FUNCT3_ADD && r2[20]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd,
                    `OPCODE_OP);
      end
      4'd11: res = enc_i(imm, rs1, `FUNCT3_ADD, rd, `OPCODE_OPIMM32);
      4'd12: res = enc_r(7'h00, rs2, rs1, `FUNCT3_ADD, rd, `OPCODE_OP32);
      // ld and sd off x0 where negative offsets land in the device page
      4'd13: res = enc_i({{4{r2[11]}}, r2[7:3], 3'b000}, 5'd0, 3'b011, rd, `OPCODE_LOAD);
      4'd14: res = enc_s({{4{r2[11]}}, r2[7:3], 3'b000}, rs2, 5'd0, 3'b011, `OPCODE_STORE);
      default: begin
        f3 = (r1[15:14] == 2'b00) ? {r1[16], 2'b01} : r1[16:14];
        case (r2[4:3])
          2'd1:    csr = `CSR_MTVEC;
          2'd3:    csr = 12'h7c0;
          default: csr = `CSR_MSCRATCH;
        endcase
        res = enc_i(csr, rs1, f3, rd, `OPCODE_SYSTEM);
      end
    endcase
    return res;
  endfunction

  function automatic xlen_t int_op(input funct3_t f3, input logic sub, input xlen_t x,
                                   input xlen_t y);
    xlen_t res;
    case (f3)
      `FUNCT3_ADD: res = sub ? x - y : x + y;
      `FUNCT3_SLL: res = x << y[5:0];
      `FUNCT3_XOR: res = x ^ y;
      `FUNCT3_SRL: res = x >> y[5:0];
      `FUNCT3_OR:  res = x | y;
      `FUNCT3_AND: res = x & y;
      default:     res = '0;
    endcase
    return res;
  endfunction

  // executes one instruction on the reference state and sets the exp_ values
  function automatic void ref_step(input inst_t word);
    funct3_t     f3;
    reg_idx_t    rd;
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    xlen_t       imm_j;
    xlen_t       npc;
    xlen_t       addr;
    xlen_t       src;
    xlen_t       upd;
    logic [31:0] sum32;
    logic        taken;
    f3    = word[14:12];
    rd    = word[11:7];
    a     = ref_regs[word[19:15]];
    b     = ref_regs[word[24:20]];
    imm_i = {{52{word[31]}}, word[31:20]};
    imm_s = {{52{word[31]}}, word[31:25], word[11:7]};
    imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_u = {{32{word[31]}}, word[31:12], 12'd0};
    imm_j = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    npc   = ref_pc + 64'd4;
    exp_pc     = ref_pc;
    exp_inst   = word;
    exp_rd     = rd;
    exp_wen    = 1'b0;
    exp_wdata  = '0;
    exp_skip   = 1'b0;
    exp_dren   = 1'b0;
    exp_dwen   = 1'b0;
    exp_daddr  = '0;
    exp_dwdata = '0;
    exp_load   = '0;
    case (word[6:2])
      `OPCODE_LUI: begin
        exp_wen   = 1'b1;
        exp_wdata = imm_u;
      end
      `OPCODE_AUIPC: begin
        exp_wen   = 1'b1;
        exp_wdata = ref_pc + imm_u;
      end
      `OPCODE_JAL: begin
        exp_wen   = 1'b1;
        exp_wdata = ref_pc + 64'd4;
        npc       = ref_pc + imm_j;
      end
      `OPCODE_JALR: begin
        exp_wen   = 1'b1;
        exp_wdata = ref_pc + 64'd4;
        npc       = (a + imm_i) & ~64'd1;
      end
      `OPCODE_BRANCH: begin
        case (f3)
          `FUNCT3_BEQ: taken = (a == b);
          `FUNCT3_BNE: taken = (a != b);
          `FUNCT3_BLT: taken = ($signed(a) < $signed(b));
          `FUNCT3_BGE: taken = ($signed(a) >= $signed(b));
          default:     taken = 1'b0;
        endcase
        if (taken) begin
          npc = ref_pc + imm_b;
        end
      end
      `OPCODE_OPIMM: begin
        exp_wen   = 1'b1;
        exp_wdata = int_op(f3, 1'b0, a, imm_i);
      end
      `OPCODE_OP: begin
        exp_wen   = 1'b1;
        exp_wdata = int_op(f3, word[30], a, b);
      end
      `OPCODE_OPIMM32, `OPCODE_OP32: begin
        sum32     = a[31:0] + ((word[6:2] == `OPCODE_OP32) ? b[31:0] : imm_i[31:0]);
        exp_wen   = 1'b1;
        exp_wdata = {{32{sum32[31]}}, sum32};
      end
      `OPCODE_LOAD: begin
        addr      = a + imm_i;
        exp_wen   = 1'b1;
        exp_dren  = 1'b1;
        exp_daddr = addr;
        exp_skip  = is_device(addr);
        exp_load  = exp_skip ? fill_word(addr) : ref_mem[addr[10:3]];
        exp_wdata = exp_load;
      end
      `OPCODE_STORE: begin
        addr       = a + imm_s;
        exp_dwen   = 1'b1;
        exp_daddr  = addr;
        exp_dwdata = b;
        exp_skip   = is_device(addr);
        if (!exp_skip) begin
          ref_mem[addr[10:3]] = b;
        end
      end
      `OPCODE_SYSTEM: begin
        exp_skip = 1'b1;
        case (word[31:20])
          `CSR_MSCRATCH: exp_wdata = ref_mscratch;
          `CSR_MTVEC:    exp_wdata = ref_mtvec;
          default:       exp_wdata = '0;
        endcase
        src = f3[2] ? {59'd0, word[19:15]} : a;
        case (f3[1:0])
          2'b01:   upd = src;
          2'b10:   upd = exp_wdata | src;
          2'b11:   upd = exp_wdata & ~src;
          default: upd = exp_wdata;
        endcase
        exp_wen = (f3[1:0] != 2'b00);
        if (word[31:20] == `CSR_MSCRATCH) begin
          ref_mscratch = upd;
        end
        if (word[31:20] == `CSR_MTVEC) begin
          ref_mtvec = upd;
        end
      end
      default: ;
    endcase
    if (rd == 5'd0) begin
      exp_wen = 1'b0;
    end
    if (exp_wen) begin
      ref_regs[rd] = exp_wdata;
    end
    ref_pc = npc;
  endfunction

  initial begin : stimulus
    int    n;
    int    waited;
    inst_t cur;
    $timeformat(-9, 0, " ns", 0);
    rst        = 1'b1;
    // a store on the bus during reset must not reach memory
    inst       = enc_s(12'd8, 5'd1, 5'd0, 3'b011, `OPCODE_STORE);
    dmem_rdata = '0;
    lcg_state  = 32'hca54;
    ref_pc       = `RESET_PC;
    ref_mscratch = '0;
    ref_mtvec    = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(xlen_t'(i) << 3);
    end
    repeat (2) @(posedge clk);
    for (n = 0; n < num_inst; n++) begin
      @(negedge clk);
      rst = 1'b0;
      check_xlen("inst_addr", inst_addr, ref_pc);
      cur = rand_inst();
      ref_step(cur);
      inst       = cur;
      dmem_rdata = exp_load;
    end
    waited = 0;
    while (n_checked < num_inst) begin
      if (waited == drain_limit) begin
        $display("Error at %t: only %0d of %0d instructions were retired", $time,
                 n_checked, num_inst);
        stop_run();
      end
      @(negedge clk);
      waited++;
    end
    $display("PASS: all tests");
    $finish;
  end

  // retire port sampled at the edge that commits the instruction
  always @(posedge clk) begin
    if (rst) begin
      check_bit("commit_valid", commit_valid, 1'b0);
      check_bit("dmem_wen", dmem_wen, 1'b0);
    end else begin
      check_bit("commit_valid", commit_valid, 1'b1);
      check_xlen("commit_pc", commit_pc, exp_pc);
      check_inst("commit_inst", commit_inst, exp_inst);
      check_bit("commit_wen", commit_wen, exp_wen);
      if (exp_wen) begin
        check_reg_idx("commit_rd", commit_rd, exp_rd);
        check_xlen("commit_wdata", commit_wdata, exp_wdata);
      end
      check_bit("commit_skip", commit_skip, exp_skip);
      check_bit("dmem_ren", dmem_ren, exp_dren);
      check_bit("dmem_wen", dmem_wen, exp_dwen);
      if (exp_dren || exp_dwen) begin
        check_xlen("dmem_addr", dmem_addr, exp_daddr);
      end
      if (exp_dwen) begin
        check_xlen("dmem_wdata", dmem_wdata, exp_dwdata);
      end
      n_checked++;
    end
  end

endmodule

// File: hw/rv64_core.sv
// rv64 single-cycle core
`timescale 1ns/10ps

module rv64_core (
  input  logic                    clk,
  input  logic                    rst,
  output rv64_core_pkg::xlen_t    inst_addr,
  input  rv64_isa_pkg::inst_t     inst,
  output logic                    dmem_ren,
  output logic                    dmem_wen,
  output rv64_core_pkg::xlen_t    dmem_addr,
  output rv64_core_pkg::xlen_t    dmem_wdata,
  input  rv64_core_pkg::xlen_t    dmem_rdata,
  output logic                    commit_valid,
  output rv64_core_pkg::xlen_t    commit_pc,
  output rv64_isa_pkg::inst_t     commit_inst,
  output logic                    commit_wen,
  output rv64_core_pkg::reg_idx_t commit_rd,
  output rv64_core_pkg::xlen_t    commit_wdata,
  output logic                    commit_skip
);
  import rv64_core_pkg::*;

  xlen_t     pc;
  logic      branch_taken;
  xlen_t     branch_target;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  logic      id_rd_wen;
  logic      rd_wen;
  xlen_t     rd_wdata;
  logic      mem_wen;
  csr_op_e   csr_op;
  csr_addr_t csr_addr;
  xlen_t     csr_wdata;
  xlen_t     csr_rdata;
  alu_op_e   alu_op;
  br_op_e    br_op;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     target;

  if_stage i_if_stage (
    .clk           (clk),
    .rst           (rst),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (pc)
  );

  id_stage i_id_stage (
    .rst       (rst),
    .inst      (inst),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .csr_rdata (csr_rdata),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .rd_wen    (id_rd_wen),
    .mem_ren   (dmem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (dmem_addr),
    .mem_wdata (dmem_wdata),
    .csr_op    (csr_op),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .alu_op    (alu_op),
    .br_op     (br_op),
    .op1       (op1),
    .op2       (op2),
    .target    (target),
    .skip      (commit_skip)
  );

  exe_stage i_exe_stage (
    .op1           (op1),
    .op2           (op2),
    .alu_op        (alu_op),
    .br_op         (br_op),
    .target        (target),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .dmem_rdata    (dmem_rdata),
    .mem_ren       (dmem_ren),
    .rd            (rd),
    .rd_wen_in     (id_rd_wen),
    .rd_wdata      (rd_wdata),
    .rd_wen        (rd_wen),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_wen   (rd_wen),
    .rd_wdata (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  csr_file i_csr_file (
    .clk       (clk),
    .rst       (rst),
    .csr_op    (csr_op),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata)
  );

  assign inst_addr = pc;

  // one instruction retires every cycle out of reset
  assign commit_valid = ~rst;
  assign dmem_wen     = mem_wen & commit_valid;
  assign commit_wen   = rd_wen & commit_valid;
  assign commit_pc    = pc;
  assign commit_inst  = inst;
  assign commit_rd    = rd;
  assign commit_wdata = rd_wdata;

endmodule

// File: hw/csr_file.sv
// machine csrs
`timescale 1ns/10ps
`include "rv64_params.svh"

module csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  rv64_core_pkg::csr_op_e   csr_op,
  input  rv64_core_pkg::csr_addr_t csr_addr,
  input  rv64_core_pkg::xlen_t     csr_wdata,
  output rv64_core_pkg::xlen_t     csr_rdata
);
  import rv64_core_pkg::*;

  xlen_t mscratch;
  xlen_t mtvec;
  xlen_t csr_next;

  // unknown addresses read zero
  always_comb begin
    case (csr_addr)
      `CSR_MSCRATCH: csr_rdata = mscratch;
      `CSR_MTVEC:    csr_rdata = mtvec;
      default:       csr_rdata = '0;
    endcase
  end

  always_comb begin
    case (csr_op)
      CSR_WRITE: csr_next = csr_wdata;
      CSR_SET:   csr_next = csr_rdata | csr_wdata;
      CSR_CLEAR: csr_next = csr_rdata & ~csr_wdata;
      default:   csr_next = csr_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mscratch <= '0;
      mtvec    <= '0;
    end else if (csr_op != CSR_NONE) begin
      if (csr_addr == `CSR_MSCRATCH) begin
        mscratch <= csr_next;
      end
      if (csr_addr == `CSR_MTVEC) begin
        mtvec <= csr_next;
      end
    end
  end

endmodule

// File: hw/regfile.sv
// integer register file
`timescale 1ns/10ps

module regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  rv64_core_pkg::reg_idx_t rs1,
  input  rv64_core_pkg::reg_idx_t rs2,
  input  rv64_core_pkg::reg_idx_t rd,
  input  logic                    rd_wen,
  input  rv64_core_pkg::xlen_t    rd_wdata,
  output rv64_core_pkg::xlen_t    rs1_data,
  output rv64_core_pkg::xlen_t    rs2_data
);
  import rv64_core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen && rd != '0) begin
      regs[rd] <= rd_wdata;
    end
  end

  // x0 never written so it reads zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// File: hw/exe_stage.sv
// alu and branch unit
`timescale 1ns/10ps

module exe_stage (
  input  rv64_core_pkg::xlen_t    op1,
  input  rv64_core_pkg::xlen_t    op2,
  input  rv64_core_pkg::alu_op_e  alu_op,
  input  rv64_core_pkg::br_op_e   br_op,
  input  rv64_core_pkg::xlen_t    target,
  input  rv64_core_pkg::xlen_t    rs1_data,
  input  rv64_core_pkg::xlen_t    rs2_data,
  input  rv64_core_pkg::xlen_t    dmem_rdata,
  input  logic                    mem_ren,
  input  rv64_core_pkg::reg_idx_t rd,
  input  logic                    rd_wen_in,
  output rv64_core_pkg::xlen_t    rd_wdata,
  output logic                    rd_wen,
  output logic                    branch_taken,
  output rv64_core_pkg::xlen_t    branch_target
);
  import rv64_core_pkg::*;

  xlen_t       alu_res;
  logic [31:0] addw_sum;

  assign addw_sum = op1[31:0] + op2[31:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_res = op1 + op2;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      ALU_SLL:  alu_res = op1 << op2[5:0];
      ALU_SRL:  alu_res = op1 >> op2[5:0];
      ALU_ADDW: alu_res = {{32{addw_sum[31]}}, addw_sum};
      default:  alu_res = op1;
    endcase
  end

  // signed compare for blt and bge
  always_comb begin
    case (br_op)
      BR_EQ:   branch_taken = (rs1_data == rs2_data);
      BR_NE:   branch_taken = (rs1_data != rs2_data);
      BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_JUMP: branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_target = target;

  // writeback select, x0 writes dropped
  assign rd_wdata = mem_ren ? dmem_rdata : alu_res;
  assign rd_wen   = rd_wen_in && (rd != '0);

endmodule

// File: hw/id_stage.sv
// instruction decoder
`timescale 1ns/10ps
`include "rv64_params.svh"

module id_stage (
  input  logic                    rst,
  input  rv64_isa_pkg::inst_t     inst,
  input  rv64_core_pkg::xlen_t    pc,
  input  rv64_core_pkg::xlen_t    rs1_data,
  input  rv64_core_pkg::xlen_t    rs2_data,
  input  rv64_core_pkg::xlen_t    csr_rdata,
  output rv64_core_pkg::reg_idx_t rs1,
  output rv64_core_pkg::reg_idx_t rs2,
  output rv64_core_pkg::reg_idx_t rd,
  output logic                    rd_wen,
  output logic                    mem_ren,
  output logic                    mem_wen,
  output rv64_core_pkg::xlen_t    mem_addr,
  output rv64_core_pkg::xlen_t    mem_wdata,
  output rv64_core_pkg::csr_op_e  csr_op,
  output rv64_core_pkg::csr_addr_t csr_addr,
  output rv64_core_pkg::xlen_t    csr_wdata,
  output rv64_core_pkg::alu_op_e  alu_op,
  output rv64_core_pkg::br_op_e   br_op,
  output rv64_core_pkg::xlen_t    op1,
  output rv64_core_pkg::xlen_t    op2,
  output rv64_core_pkg::xlen_t    target,
  output logic                    skip
);
  import rv64_isa_pkg::*;
  import rv64_core_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  itype_e  itype;
  xlen_t   imm_i;
  xlen_t   imm_s;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   imm_j;
  xlen_t   imm;
  xlen_t   shamt;
  xlen_t   csr_zimm;
  xlen_t   jalr_sum;
  logic    is_mem;
  logic    dev_hit;

  // shared by OP and OP-IMM, unsupported codes fall back to PASS
  function automatic alu_op_e alu_sel(input funct3_t f3, input logic sub);
    alu_op_e op;
    case (f3)
      `FUNCT3_ADD: op = sub ? ALU_SUB : ALU_ADD;
      `FUNCT3_SLL: op = ALU_SLL;
      `FUNCT3_XOR: op = ALU_XOR;
      `FUNCT3_SRL: op = ALU_SRL;
      `FUNCT3_OR:  op = ALU_OR;
      `FUNCT3_AND: op = ALU_AND;
      default:     op = ALU_PASS;
    endcase
    return op;
  endfunction

  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // immediates, all sign-extended to 64 bits
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign shamt    = {58'd0, inst[25:20]};
  assign csr_zimm = {59'd0, inst[19:15]};

  always_comb begin
    case (opcode)
      `OPCODE_LUI, `OPCODE_AUIPC:  itype = ITYPE_U;
      `OPCODE_JAL:                 itype = ITYPE_J;
      `OPCODE_BRANCH:              itype = ITYPE_B;
      `OPCODE_STORE:               itype = ITYPE_S;
      `OPCODE_OP, `OPCODE_OP32:    itype = ITYPE_R;
      `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OPIMM,
      `OPCODE_OPIMM32, `OPCODE_SYSTEM: itype = ITYPE_I;
      default:                     itype = ITYPE_NONE;
    endcase
  end

  always_comb begin
    case (itype)
      ITYPE_I: imm = imm_i;
      ITYPE_S: imm = imm_s;
      ITYPE_B: imm = imm_b;
      ITYPE_U: imm = imm_u;
      ITYPE_J: imm = imm_j;
      default: imm = '0;
    endcase
  end

  assign jalr_sum  = rs1_data + imm;
  assign mem_addr  = rs1_data + imm;
  assign mem_wdata = rs2_data;
  assign csr_addr  = inst[31:20];
  assign csr_wdata = funct3[2] ? csr_zimm : rs1_data;

  always_comb begin
    rd_wen  = 1'b0;
    mem_ren = 1'b0;
    mem_wen = 1'b0;
    csr_op  = CSR_NONE;
    alu_op  = ALU_PASS;
    br_op   = BR_NONE;
    op1     = '0;
    op2     = '0;
    target  = pc + imm;
    case (opcode)
      `OPCODE_LUI: begin
        rd_wen = 1'b1;
        op1    = imm;
      end
      `OPCODE_AUIPC: begin
        rd_wen = 1'b1;
        alu_op = ALU_ADD;
        op1    = pc;
        op2    = imm;
      end
      `OPCODE_JAL, `OPCODE_JALR: begin
        rd_wen = 1'b1;
        br_op  = BR_JUMP;
        op1    = pc + 64'd4;
        if (opcode == `OPCODE_JALR) begin
          target = {jalr_sum[63:1], 1'b0};
        end
      end
      `OPCODE_BRANCH: begin
        case (funct3)
          `FUNCT3_BEQ: br_op = BR_EQ;
          `FUNCT3_BNE: br_op = BR_NE;
          `FUNCT3_BLT: br_op = BR_LT;
          `FUNCT3_BGE: br_op = BR_GE;
          default:     br_op = BR_NONE;
        endcase
      end
      `OPCODE_LOAD: begin
        rd_wen  = 1'b1;
        mem_ren = 1'b1;
      end
      `OPCODE_STORE: mem_wen = 1'b1;
      `OPCODE_OPIMM: begin
        alu_op = alu_sel(funct3, 1'b0);
        rd_wen = (alu_op != ALU_PASS);
        op1    = rs1_data;
        op2    = (alu_op == ALU_SLL || alu_op == ALU_SRL) ? shamt : imm;
      end
      `OPCODE_OP: begin
        alu_op = alu_sel(funct3, funct7[5]);
        rd_wen = (alu_op != ALU_PASS);
        op1    = rs1_data;
        op2    = rs2_data;
      end
      `OPCODE_OPIMM32, `OPCODE_OP32: begin
        // only ADDIW and ADDW
        if (funct3 == `FUNCT3_ADD && !(opcode == `OPCODE_OP32 && funct7[5])) begin
          rd_wen = 1'b1;
          alu_op = ALU_ADDW;
          op1    = rs1_data;
          op2    = (opcode == `OPCODE_OP32) ? rs2_data : imm;
        end
      end
      `OPCODE_SYSTEM: begin
        case (funct3)
          `FUNCT3_CSRRW, `FUNCT3_CSRRWI: csr_op = CSR_WRITE;
          `FUNCT3_CSRRS, `FUNCT3_CSRRSI: csr_op = CSR_SET;
          `FUNCT3_CSRRC, `FUNCT3_CSRRCI: csr_op = CSR_CLEAR;
          default:                       csr_op = CSR_NONE;
        endcase
        // old csr value goes to rd
        rd_wen = (csr_op != CSR_NONE);
        op1    = csr_rdata;
      end
      default: ;
    endcase
    // no side effects while held in reset
    if (rst) begin
      rd_wen  = 1'b0;
      mem_ren = 1'b0;
      mem_wen = 1'b0;
      csr_op  = CSR_NONE;
    end
  end

  assign is_mem  = (opcode == `OPCODE_LOAD) || (opcode == `OPCODE_STORE);
  assign dev_hit = (mem_addr & ~64'hFFF) == `DEVICE_PAGE;

  // reference model does not track csr or device state
  assign skip = (opcode == `OPCODE_SYSTEM) || (is_mem && dev_hit);

endmodule

// File: hw/if_stage.sv
// program counter
`timescale 1ns/10ps
`include "rv64_params.svh"

module if_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 branch_taken,
  input  rv64_core_pkg::xlen_t branch_target,
  output rv64_core_pkg::xlen_t pc
);
  import rv64_core_pkg::*;

  xlen_t pc_next;

  // taken branch or jump overrides sequential fetch
  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: hw/rv64_core_pkg.sv
// rv64 datapath types
package rv64_core_pkg;

  // data and address word
  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // alu operations, W forms sign-extend bit 31
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_ADDW = 4'd7,
    ALU_PASS = 4'd8
  } alu_op_e;

  // csr read-modify-write
  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4,
    BR_JUMP = 3'd5
  } br_op_e;

endpackage

// File: hw/rv64_isa_pkg.sv
// rv64 isa types
package rv64_isa_pkg;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // major opcode, bits 6 to 2
  typedef logic [4:0] opcode_t;

  // minor function codes
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // instruction formats, picks the immediate layout
  typedef enum logic [2:0] {
    ITYPE_R    = 3'd0,
    ITYPE_I    = 3'd1,
    ITYPE_S    = 3'd2,
    ITYPE_B    = 3'd3,
    ITYPE_U    = 3'd4,
    ITYPE_J    = 3'd5,
    ITYPE_NONE = 3'd7
  } itype_e;

endpackage

// File: hw/rv64_params.svh
// rv64 core constants
`ifndef RV64_PARAMS_SVH
`define RV64_PARAMS_SVH

// major opcodes, instruction bits 6 to 2
`define OPCODE_LUI      5'b01101
`define OPCODE_AUIPC    5'b00101
`define OPCODE_JAL      5'b11011
`define OPCODE_JALR     5'b11001
`define OPCODE_BRANCH   5'b11000
`define OPCODE_LOAD     5'b00000
`define OPCODE_STORE    5'b01000
`define OPCODE_OPIMM    5'b00100
`define OPCODE_OP       5'b01100
`define OPCODE_OPIMM32  5'b00110
`define OPCODE_OP32     5'b01110
`define OPCODE_SYSTEM   5'b11100

// alu group
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL      3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// branch group
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101

// csr group
`define FUNCT3_CSRRW    3'b001
`define FUNCT3_CSRRS    3'b010
`define FUNCT3_CSRRC    3'b011
`define FUNCT3_CSRRWI   3'b101
`define FUNCT3_CSRRSI   3'b110
`define FUNCT3_CSRRCI   3'b111

`define CSR_MSCRATCH    12'h340
`define CSR_MTVEC       12'h305

`define RESET_PC        64'h0000_0000_8000_0000
// compared against an address with its low 12 bits cleared
`define DEVICE_PAGE     64'hFFFF_FFFF_FFFF_F000

`endif
